// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

   typedef logic [31:0] inst_t;
   typedef logic [31:0] word_t;
   typedef logic [4:0]  regIdx_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [3:0]  aluOp_t;
   typedef logic [2:0]  immType_t;

   // Opcode field, instruction bits 6 to 2
   localparam opcode_t OP_LOAD   = 5'd0;
   localparam opcode_t OP_RST    = 5'd1;
   localparam opcode_t OP_X      = 5'd2;
   localparam opcode_t OP_I      = 5'd4;
   localparam opcode_t OP_AUIPC  = 5'd5;
   localparam opcode_t OP_STORE  = 5'd8;
   localparam opcode_t OP_R      = 5'd12;
   localparam opcode_t OP_LUI    = 5'd13;
   localparam opcode_t OP_BRANCH = 5'd24;
   localparam opcode_t OP_JALR   = 5'd25;
   localparam opcode_t OP_JAL    = 5'd27;
   localparam opcode_t OP_CSRW   = 5'd28;

   localparam aluOp_t ALU_ADD = 4'd0;
   // Operand B straight through
   localparam aluOp_t ALU_B   = 4'd9;

   localparam immType_t IMM_I = 3'd1;
   localparam immType_t IMM_S = 3'd2;
   localparam immType_t IMM_B = 3'd3;
   localparam immType_t IMM_U = 3'd4;
   localparam immType_t IMM_J = 3'd5;
   localparam immType_t IMM_X = 3'd6;

   // Branch funct3
   localparam logic [2:0] BEQ  = 3'd0;
   localparam logic [2:0] BNE  = 3'd1;
   localparam logic [2:0] BLT  = 3'd4;
   localparam logic [2:0] BGE  = 3'd5;
   localparam logic [2:0] BLTU = 3'd6;
   localparam logic [2:0] BGEU = 3'd7;

   // Shift funct3 in the I-type group, these take funct7 bit 30
   localparam logic [2:0] F3_SLL = 3'd1;
   localparam logic [2:0] F3_SR  = 3'd5;

   // UART register window
   localparam word_t UART_CTRL = 32'h8000_0000;
   localparam word_t UART_RX   = 32'h8000_0004;
   localparam word_t UART_TX   = 32'h8000_0008;
   localparam word_t UART_CC   = 32'h8000_0010;
   localparam word_t UART_IC   = 32'h8000_0014;
   localparam word_t UART_RST  = 32'h8000_0018;

   localparam logic [2:0] MMAP_LOAD  = 3'd1;
   localparam logic [2:0] MMAP_STORE = 3'd2;
   localparam logic [2:0] MMAP_NOP   = 3'd6;
   localparam logic [2:0] MMAP_X     = 3'd7;

   localparam logic [1:0] PC_NEXT     = 2'd0;
   localparam logic [1:0] PC_TAKEN    = 2'd1;
   localparam logic [1:0] PC_REDIRECT = 2'd2;

   // Writeback source
   localparam logic [1:0] WB_MEM = 2'd0;
   localparam logic [1:0] WB_ALU = 2'd1;
   localparam logic [1:0] WB_PC4 = 2'd2;

   localparam logic [2:0] LD_X      = 3'd7;
   localparam logic [1:0] SIZE_NONE = 2'd3;

   localparam word_t RESET_PC   = 32'h4000_0000;
   // Opcode field of this word decodes as OP_RST
   localparam inst_t RESET_MARK = RESET_PC + 32'd4;

   typedef struct packed {
      logic       aSel;
      logic       bSel;
      aluOp_t     aluSel;
      logic [1:0] sSel;
      logic       instSel;
      logic [1:0] pcSel;
      logic       csrEn;
      logic       csrSel;
      logic [2:0] mmapSel;
   } exCtrl_t;

   typedef struct packed {
      logic [2:0] ldSel;
      logic [1:0] wbSel;
      logic       regWrEn;
   } wbCtrl_t;

   typedef struct packed {
      logic faDec;
      logic fbDec;
      logic faEx;
      logic fbEx;
   } fwdSel_t;

endpackage

// ==== rtl/instPipe.sv ====
module instPipe (
   input  logic           clk,
   input  logic           rst,
   input  ctrlPkg::inst_t inst,
   input  ctrlPkg::word_t aluOut,
   output ctrlPkg::inst_t exInst,
   output ctrlPkg::inst_t wbInst,
   output ctrlPkg::word_t wbAluOut
);
   import ctrlPkg::*;

   // Decode to execute to writeback, no stall
   always_ff @(posedge clk) begin
      if (rst) begin
         exInst <= RESET_MARK;
         wbInst <= RESET_MARK;
      end else begin
         exInst <= inst;
         wbInst <= exInst;
      end
   end

   // Load address kept for the writeback window check
   always_ff @(posedge clk) begin
      if (rst) begin
         wbAluOut <= '0;
      end else begin
         wbAluOut <= aluOut;
      end
   end

endmodule

// ==== rtl/decodeControl.sv ====
module decodeControl (
   input  ctrlPkg::inst_t    inst,
   output ctrlPkg::immType_t immSel
);
   import ctrlPkg::*;

   opcode_t opcode;

   assign opcode = inst[6:2];

   always_comb begin
      case (opcode)
         OP_LOAD,
         OP_JALR,
         OP_I:      immSel = IMM_I;
         OP_STORE:  immSel = IMM_S;
         OP_BRANCH: immSel = IMM_B;
         OP_AUIPC,
         OP_LUI:    immSel = IMM_U;
         OP_JAL:    immSel = IMM_J;
         // R-type and CSRW carry no immediate
         default:   immSel = IMM_X;
      endcase
   end

endmodule

// ==== rtl/forwardUnit.sv ====
module forwardUnit (
   input  ctrlPkg::inst_t   inst,
   input  ctrlPkg::inst_t   exInst,
   input  ctrlPkg::inst_t   wbInst,
   output ctrlPkg::fwdSel_t fwd
);
   import ctrlPkg::*;

   regIdx_t wbRd;
   logic    wbWrites;

   function automatic logic writesRd(opcode_t op);
      return !(op inside {OP_BRANCH, OP_STORE, OP_X, OP_RST});
   endfunction

   function automatic logic readsRs1(opcode_t op);
      return !(op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_X, OP_RST});
   endfunction

   // rs2 readers are a subset of the rs1 readers
   function automatic logic readsRs2(opcode_t op);
      return readsRs1(op) && !(op inside {OP_JALR, OP_LOAD, OP_I, OP_CSRW});
   endfunction

   function automatic logic fwdRs1(inst_t consumer, regIdx_t rd, logic rdValid);
      regIdx_t rs1;
      opcode_t op;
      rs1 = consumer[19:15];
      op  = consumer[6:2];
      if (!rdValid || !readsRs1(op) || rd != rs1) begin
         return 1'b0;
      end
      // CSRW forwards even on x0
      if (op == OP_CSRW) begin
         return 1'b1;
      end
      return rs1 != '0;
   endfunction

   function automatic logic fwdRs2(inst_t consumer, regIdx_t rd, logic rdValid);
      regIdx_t rs2;
      rs2 = consumer[24:20];
      return rdValid && readsRs2(consumer[6:2]) && (rd == rs2) && (rs2 != '0);
   endfunction

   assign wbRd     = wbInst[11:7];
   assign wbWrites = writesRd(wbInst[6:2]);

   // Only the writeback stage is a forwarding source
   always_comb begin
      fwd.faDec = fwdRs1(inst, wbRd, wbWrites);
      fwd.fbDec = fwdRs2(inst, wbRd, wbWrites);
      fwd.faEx  = fwdRs1(exInst, wbRd, wbWrites);
      fwd.fbEx  = fwdRs2(exInst, wbRd, wbWrites);
   end

endmodule

// ==== rtl/exControl.sv ====
module exControl (
   input  ctrlPkg::inst_t   exInst,
   input  logic             brEq,
   input  logic             brLt,
   input  ctrlPkg::word_t   aluOut,
   output ctrlPkg::exCtrl_t exCtrl,
   output logic             brUn,
   output logic             memRw,
   output logic             uartRxRead,
   output logic             uartTxWrite
);
   import ctrlPkg::*;

   opcode_t    opcode;
   logic [2:0] funct3;
   logic       isLoad;
   logic       isStore;
   logic       uartHit;

   assign opcode  = exInst[6:2];
   assign funct3  = exInst[14:12];
   assign isLoad  = (opcode == OP_LOAD);
   assign isStore = (opcode == OP_STORE);

   always_comb begin
      exCtrl.aSel    = 1'b0;
      exCtrl.bSel    = 1'b1;
      exCtrl.aluSel  = ALU_ADD;
      exCtrl.sSel    = SIZE_NONE;
      exCtrl.instSel = 1'b0;
      exCtrl.pcSel   = PC_NEXT;
      exCtrl.csrEn   = 1'b0;
      exCtrl.csrSel  = 1'b0;
      exCtrl.mmapSel = MMAP_X;
      case (opcode)
         OP_LOAD: exCtrl.mmapSel = MMAP_LOAD;
         OP_STORE: begin
            exCtrl.sSel    = funct3[1:0];
            exCtrl.mmapSel = MMAP_STORE;
         end
         OP_BRANCH: begin
            exCtrl.aSel    = 1'b1;
            exCtrl.instSel = 1'b1;
            exCtrl.mmapSel = MMAP_NOP;
            case (funct3)
               BEQ:  exCtrl.pcSel = brEq ? PC_TAKEN : PC_REDIRECT;
               BNE:  exCtrl.pcSel = brEq ? PC_REDIRECT : PC_TAKEN;
               BLT,
               BLTU: exCtrl.pcSel = brLt ? PC_TAKEN : PC_REDIRECT;
               BGE,
               BGEU: exCtrl.pcSel = brLt ? PC_REDIRECT : PC_TAKEN;
               default: exCtrl.pcSel = PC_NEXT;
            endcase
         end
         OP_JALR: begin
            exCtrl.instSel = 1'b1;
            exCtrl.pcSel   = PC_TAKEN;
            exCtrl.mmapSel = MMAP_NOP;
         end
         OP_JAL: begin
            exCtrl.aSel    = 1'b1;
            exCtrl.instSel = 1'b1;
            exCtrl.pcSel   = PC_TAKEN;
            exCtrl.mmapSel = MMAP_NOP;
         end
         OP_R: begin
            exCtrl.bSel   = 1'b0;
            exCtrl.aluSel = {exInst[30], funct3};
         end
         OP_I: begin
            // Bit 30 is part of the immediate except for shifts
            if (funct3 == F3_SLL || funct3 == F3_SR) begin
               exCtrl.aluSel = {exInst[30], funct3};
            end else begin
               exCtrl.aluSel = {1'b0, funct3};
            end
         end
         OP_AUIPC: exCtrl.aSel = 1'b1;
         OP_LUI: exCtrl.aluSel = ALU_B;
         OP_CSRW: begin
            exCtrl.bSel   = 1'b0;
            exCtrl.aluSel = ALU_B;
            exCtrl.csrEn  = 1'b1;
            exCtrl.csrSel = exInst[14];
         end
         OP_RST: begin
            // Refetch from the reset PC with a NOP injected
            exCtrl.aluSel  = ALU_B;
            exCtrl.instSel = 1'b1;
            exCtrl.pcSel   = PC_REDIRECT;
         end
         default: begin
            exCtrl.aluSel  = ALU_B;
            exCtrl.instSel = 1'b1;
         end
      endcase
   end

   assign brUn = (opcode == OP_BRANCH) && (funct3 == BLTU || funct3 == BGEU);

   // Memory map decode on the effective address
   assign uartHit = aluOut inside {UART_CTRL, UART_RX, UART_TX, UART_CC, UART_IC, UART_RST};

   assign memRw       = (isLoad || isStore) && !uartHit;
   assign uartRxRead  = isLoad && (aluOut == UART_RX);
   assign uartTxWrite = isStore && (aluOut == UART_TX);

endmodule

// ==== rtl/wbControl.sv ====
module wbControl (
   input  ctrlPkg::inst_t   wbInst,
   input  ctrlPkg::word_t   wbAluOut,
   output ctrlPkg::wbCtrl_t wbCtrl
);
   import ctrlPkg::*;

   opcode_t    opcode;
   logic [3:0] region;

   assign opcode = wbInst[6:2];
   assign region = wbAluOut[31:28];

   always_comb begin
      // Non-writers: store, branch, CSRW, reset marker, unknown
      wbCtrl.ldSel   = LD_X;
      wbCtrl.wbSel   = WB_MEM;
      wbCtrl.regWrEn = 1'b0;
      case (opcode)
         OP_LOAD: begin
            wbCtrl.ldSel   = wbInst[14:12];
            wbCtrl.wbSel   = WB_MEM;
            // Regions that return load data, UART included at nibble 8
            wbCtrl.regWrEn = region inside {4'h1, 4'h3, 4'h4, 4'h8};
         end
         OP_R,
         OP_I,
         OP_AUIPC,
         OP_LUI: begin
            wbCtrl.wbSel   = WB_ALU;
            wbCtrl.regWrEn = 1'b1;
         end
         OP_JAL,
         OP_JALR: begin
            wbCtrl.wbSel   = WB_PC4;
            wbCtrl.regWrEn = 1'b1;
         end
         default: wbCtrl.regWrEn = 1'b0;
      endcase
   end

endmodule

// ==== rtl/pipeControl.sv ====
module pipeControl (
   input  logic              clk,
   input  logic              rst,
   input  ctrlPkg::inst_t    inst,
   input  logic              brEq,
   input  logic              brLt,
   input  ctrlPkg::word_t    aluOut,
   output ctrlPkg::immType_t immSel,
   output ctrlPkg::exCtrl_t  exCtrl,
   output logic              brUn,
   output logic              memRw,
   output logic              uartRxRead,
   output logic              uartTxWrite,
   output ctrlPkg::wbCtrl_t  wbCtrl,
   output ctrlPkg::fwdSel_t  fwd
);
   import ctrlPkg::*;

   inst_t exInst;
   inst_t wbInst;
   word_t wbAluOut;

   instPipe i_instPipe (
      .clk      (clk),
      .rst      (rst),
      .inst     (inst),
      .aluOut   (aluOut),
      .exInst   (exInst),
      .wbInst   (wbInst),
      .wbAluOut (wbAluOut)
   );

   decodeControl i_decodeControl (
      .inst   (inst),
      .immSel (immSel)
   );

   forwardUnit i_forwardUnit (
      .inst   (inst),
      .exInst (exInst),
      .wbInst (wbInst),
      .fwd    (fwd)
   );

   exControl i_exControl (
      .exInst      (exInst),
      .brEq        (brEq),
      .brLt        (brLt),
      .aluOut      (aluOut),
      .exCtrl      (exCtrl),
      .brUn        (brUn),
      .memRw       (memRw),
      .uartRxRead  (uartRxRead),
      .uartTxWrite (uartTxWrite)
   );

   wbControl i_wbControl (
      .wbInst   (wbInst),
      .wbAluOut (wbAluOut),
      .wbCtrl   (wbCtrl)
   );

endmodule

// ==== test/pipeControlTb.sv ====
module pipeControlTb;
   timeunit 1ns;
   timeprecision 100ps;
   import ctrlPkg::*;

   // Cycles each test spends, used to size the watchdog
   localparam int RESET_CYCLES  = 6;
   localparam int SELECT_CYCLES = 8;
   localparam int BRANCH_RUNS   = 12;
   localparam int BRANCH_CYCLES = BRANCH_RUNS * 2 + 4;
   localparam int MEM_CYCLES    = 10 * 2 * 3;
   localparam int WB_CYCLES     = 14;
   localparam int FWD_RANDOM    = 16;
   localparam int FWD_CYCLES    = 13 + FWD_RANDOM + 2;
   localparam int TOTAL_CYCLES  = RESET_CYCLES + SELECT_CYCLES + BRANCH_CYCLES
                                  + MEM_CYCLES + WB_CYCLES + FWD_CYCLES;

   // addi x0, x0, 0
   localparam inst_t NOP = 32'h0000_0013;

   logic     clk = 1'b0;
   logic     rst;
   inst_t    inst;
   logic     brEq;
   logic     brLt;
   word_t    aluOut;
   immType_t immSel;
   exCtrl_t  exCtrl;
   logic     brUn;
   logic     memRw;
   logic     uartRxRead;
   logic     uartTxWrite;
   wbCtrl_t  wbCtrl;
   fwdSel_t  fwd;

   integer seed = 32'he21a_dc98;
   int     checks = 0;
   int     errors = 0;

   pipeControl i_dut (
      .clk         (clk),
      .rst         (rst),
      .inst        (inst),
      .brEq        (brEq),
      .brLt        (brLt),
      .aluOut      (aluOut),
      .immSel      (immSel),
      .exCtrl      (exCtrl),
      .brUn        (brUn),
      .memRw       (memRw),
      .uartRxRead  (uartRxRead),
      .uartTxWrite (uartTxWrite),
      .wbCtrl      (wbCtrl),
      .fwd         (fwd)
   );

   always #50 clk = ~clk;

   function automatic inst_t mkInst(opcode_t op, regIdx_t rd, logic [2:0] f3,
                                    regIdx_t rs1, regIdx_t rs2, logic b30);
      return {1'b0, b30, 5'b0, rs2, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic immType_t expImm(inst_t w);
      case (w[6:2])
         OP_LOAD, OP_JALR, OP_I: return IMM_I;
         OP_STORE:               return IMM_S;
         OP_BRANCH:              return IMM_B;
         OP_AUIPC, OP_LUI:       return IMM_U;
         OP_JAL:                 return IMM_J;
         default:                return IMM_X;
      endcase
   endfunction

   function automatic aluOp_t expAlu(inst_t w);
      logic [2:0] f3;
      f3 = w[14:12];
      case (w[6:2])
         OP_R:            return {w[30], f3};
         OP_I:            return (f3 == F3_SLL || f3 == F3_SR) ? {w[30], f3} : {1'b0, f3};
         OP_LUI, OP_CSRW: return ALU_B;
         default:         return ALU_ADD;
      endcase
   endfunction

   // Expected {rs1 select, rs2 select} for consumer c against writeback producer p
   function automatic logic [1:0] expFwd(inst_t c, inst_t p);
      opcode_t cop;
      opcode_t pop;
      logic    writes;
      logic    useRs1;
      logic    useRs2;
      logic    fa;
      logic    fb;
      cop    = c[6:2];
      pop    = p[6:2];
      writes = !(pop inside {OP_BRANCH, OP_STORE, OP_X, OP_RST});
      useRs1 = !(cop inside {OP_LUI, OP_AUIPC, OP_JAL, OP_X, OP_RST});
      useRs2 = useRs1 && !(cop inside {OP_JALR, OP_LOAD, OP_I, OP_CSRW});
      fa = writes && useRs1 && (p[11:7] == c[19:15]) && (c[19:15] != 5'd0 || cop == OP_CSRW);
      fb = writes && useRs2 && (p[11:7] == c[24:20]) && (c[24:20] != 5'd0);
      return {fa, fb};
   endfunction

   task automatic check(string name, logic [31:0] exp, logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
      end
   endtask

   task automatic report(string name, int startErr);
      $display("%s: finished with %0d errors", name, errors - startErr);
   endtask

   // Drive one decode slot, then wait until the outputs have settled
   task automatic tick(inst_t w, logic eq, logic lt, word_t alu);
      @(posedge clk);
      #10;
      inst   = w;
      brEq   = eq;
      brLt   = lt;
      aluOut = alu;
      #30;
   endtask

   task automatic checkReset();
      check("regWrEn", 32'(1'b0), 32'(wbCtrl.regWrEn));
      check("memRw", 32'(1'b0), 32'(memRw));
      check("csrEn", 32'(1'b0), 32'(exCtrl.csrEn));
      check("uartRxRead", 32'(1'b0), 32'(uartRxRead));
      check("uartTxWrite", 32'(1'b0), 32'(uartTxWrite));
      check("fwd", 32'(4'b0), 32'(fwd));
      check("pcSel", 32'(PC_REDIRECT), 32'(exCtrl.pcSel));
      check("instSel", 32'(1'b1), 32'(exCtrl.instSel));
   endtask

   task automatic checkExec(inst_t w);
      opcode_t op;
      op = w[6:2];
      check("aSel", 32'(op == OP_AUIPC), 32'(exCtrl.aSel));
      check("bSel", 32'(!(op == OP_R || op == OP_CSRW)), 32'(exCtrl.bSel));
      check("aluSel", 32'(expAlu(w)), 32'(exCtrl.aluSel));
      check("csrEn", 32'(op == OP_CSRW), 32'(exCtrl.csrEn));
      check("csrSel", 32'(op == OP_CSRW && w[14]), 32'(exCtrl.csrSel));
      // Neither memory access nor control transfer in this group
      check("sSel", 32'(SIZE_NONE), 32'(exCtrl.sSel));
      check("mmapSel", 32'(MMAP_X), 32'(exCtrl.mmapSel));
   endtask

   task automatic checkWb(inst_t w, word_t a);
      logic isLoad;
      logic aluSrc;
      logic jump;
      logic expWr;
      isLoad = (w[6:2] == OP_LOAD);
      aluSrc = w[6:2] inside {OP_R, OP_I, OP_AUIPC, OP_LUI};
      jump   = w[6:2] inside {OP_JAL, OP_JALR};
      expWr  = isLoad ? (a[31:28] inside {4'h1, 4'h3, 4'h4, 4'h8}) : (aluSrc || jump);
      check("regWrEn", 32'(expWr), 32'(wbCtrl.regWrEn));
      check("ldSel", 32'(isLoad ? w[14:12] : LD_X), 32'(wbCtrl.ldSel));
      if (isLoad || aluSrc || jump) begin
         check("wbSel", 32'(isLoad ? 2'd0 : (aluSrc ? 2'd1 : 2'd2)), 32'(wbCtrl.wbSel));
      end
   endtask

   task automatic resetTest();
      int startErr;
      startErr = errors;
      repeat (3) @(posedge clk);
      #40;
      checkReset();
      repeat (2) @(posedge clk);
      #10;
      rst = 1'b0;
      #30;
      // Registers still hold the reset marker here
      checkReset();
      report("reset", startErr);
   endtask

   task automatic selectTest();
      inst_t words[7];
      int    startErr;
      startErr = errors;
      words[0] = mkInst(OP_R, 5'd1, 3'd0, 5'd2, 5'd3, 1'b1);
      words[1] = mkInst(OP_I, 5'd4, 3'd7, 5'd5, 5'd9, 1'b1);
      words[2] = mkInst(OP_I, 5'd6, F3_SR, 5'd7, 5'd2, 1'b1);
      words[3] = mkInst(OP_LUI, 5'd8, 3'd3, 5'd1, 5'd1, 1'b0);
      words[4] = mkInst(OP_AUIPC, 5'd9, 3'd2, 5'd4, 5'd0, 1'b0);
      words[5] = mkInst(OP_CSRW, 5'd0, 3'd5, 5'd8, 5'd0, 1'b0);
      words[6] = mkInst(OP_CSRW, 5'd0, 3'd1, 5'd3, 5'd0, 1'b0);
      for (int i = 0; i < SELECT_CYCLES; i++) begin
         tick(i < 7 ? words[i] : NOP, 1'b0, 1'b0, 32'h0);
         if (i < 7) begin
            check("immSel", 32'(expImm(words[i])), 32'(immSel));
         end
         if (i > 0) begin
            checkExec(words[i - 1]);
         end
      end
      report("decode and execute selects", startErr);
   endtask

   task automatic branchTest();
      logic [2:0]  codes[6];
      logic [2:0]  f3;
      logic [31:0] r;
      logic        taken;
      inst_t       w;
      int          startErr;
      startErr = errors;
      codes = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
      for (int i = 0; i < BRANCH_RUNS; i++) begin
         r  = $random(seed);
         f3 = codes[i % 6];
         w  = mkInst(OP_BRANCH, r[4:0], f3, r[9:5], r[14:10], 1'b0);
         tick(w, 1'b0, 1'b0, 32'h0);
         tick(NOP, r[15], r[16], 32'h0);
         case (f3)
            BEQ:        taken = r[15];
            BNE:        taken = !r[15];
            BLT, BLTU:  taken = r[16];
            default:    taken = !r[16];
         endcase
         check("pcSel", 32'(taken ? PC_TAKEN : PC_REDIRECT), 32'(exCtrl.pcSel));
         check("brUn", 32'(f3 == BLTU || f3 == BGEU), 32'(brUn));
         check("mmapSel", 32'(MMAP_NOP), 32'(exCtrl.mmapSel));
      end
      for (int j = 0; j < 2; j++) begin
         w = (j == 0) ? mkInst(OP_JAL, 5'd1, 3'd0, 5'd0, 5'd0, 1'b0)
                      : mkInst(OP_JALR, 5'd1, 3'd0, 5'd5, 5'd0, 1'b0);
         tick(w, 1'b0, 1'b0, 32'h0);
         tick(NOP, 1'b0, 1'b0, 32'h0);
         check("pcSel", 32'(PC_TAKEN), 32'(exCtrl.pcSel));
         check("instSel", 32'(1'b1), 32'(exCtrl.instSel));
         check("mmapSel", 32'(MMAP_NOP), 32'(exCtrl.mmapSel));
      end
      report("branch and jump resolution", startErr);
   endtask

   task automatic memTest();
      word_t addrs[10];
      word_t a;
      inst_t w;
      logic  isUart;
      int    startErr;
      startErr = errors;
      addrs = '{32'h1000_0100, 32'h2000_0040, 32'h4000_0008, 32'h8000_000c, UART_CTRL,
                UART_RX, UART_TX, UART_CC, UART_IC, UART_RST};
      foreach (addrs[k]) begin
         for (int s = 0; s < 2; s++) begin
            a      = addrs[k];
            isUart = a inside {UART_CTRL, UART_RX, UART_TX, UART_CC, UART_IC, UART_RST};
            w = (s == 1) ? mkInst(OP_STORE, 5'd4, 3'd2, 5'd1, 5'd2, 1'b0)
                         : mkInst(OP_LOAD, 5'd3, 3'd2, 5'd1, 5'd0, 1'b0);
            tick(w, 1'b0, 1'b0, 32'h0);
            tick(NOP, 1'b0, 1'b0, a);
            check("memRw", 32'(!isUart), 32'(memRw));
            check("uartRxRead", 32'(s == 0 && a == UART_RX), 32'(uartRxRead));
            check("uartTxWrite", 32'(s == 1 && a == UART_TX), 32'(uartTxWrite));
            check("mmapSel", 32'((s == 1) ? MMAP_STORE : MMAP_LOAD), 32'(exCtrl.mmapSel));
            check("sSel", 32'((s == 1) ? w[13:12] : SIZE_NONE), 32'(exCtrl.sSel));
            tick(NOP, 1'b0, 1'b0, 32'h0);
            check("regWrEn", 32'(s == 0 && (a[31:28] inside {4'h1, 4'h3, 4'h4, 4'h8})),
                  32'(wbCtrl.regWrEn));
         end
      end
      report("memory map", startErr);
   endtask

   task automatic wbTest();
      inst_t words[12];
      word_t addrs[12];
      int    startErr;
      startErr = errors;
      words[0]  = mkInst(OP_LOAD, 5'd3, 3'd2, 5'd1, 5'd0, 1'b0);
      words[1]  = mkInst(OP_LOAD, 5'd4, 3'd4, 5'd1, 5'd0, 1'b0);
      words[2]  = mkInst(OP_LOAD, 5'd5, 3'd1, 5'd1, 5'd0, 1'b0);
      words[3]  = mkInst(OP_R, 5'd6, 3'd0, 5'd1, 5'd2, 1'b0);
      words[4]  = mkInst(OP_I, 5'd7, 3'd4, 5'd1, 5'd3, 1'b0);
      words[5]  = mkInst(OP_AUIPC, 5'd8, 3'd0, 5'd0, 5'd0, 1'b0);
      words[6]  = mkInst(OP_LUI, 5'd9, 3'd0, 5'd0, 5'd0, 1'b0);
      words[7]  = mkInst(OP_JAL, 5'd1, 3'd0, 5'd0, 5'd0, 1'b0);
      words[8]  = mkInst(OP_JALR, 5'd2, 3'd0, 5'd1, 5'd0, 1'b0);
      words[9]  = mkInst(OP_STORE, 5'd4, 3'd2, 5'd1, 5'd2, 1'b0);
      words[10] = mkInst(OP_BRANCH, 5'd4, 3'd0, 5'd1, 5'd2, 1'b0);
      words[11] = mkInst(OP_CSRW, 5'd0, 3'd1, 5'd3, 5'd0, 1'b0);
      addrs = '{32'h3000_0010, 32'h2000_0000, UART_RX, 32'h0, 32'h0, 32'h0, 32'h0,
                32'h0, 32'h0, 32'h1000_0000, 32'h0, 32'h0};
      for (int i = 0; i < WB_CYCLES; i++) begin
         // aluOut belongs to the instruction now in execute
         tick(i < 12 ? words[i] : NOP, 1'b0, 1'b0,
              (i > 0 && i <= 12) ? addrs[i - 1] : 32'h0);
         if (i >= 2) begin
            checkWb(words[i - 2], addrs[i - 2]);
         end
      end
      report("writeback controls", startErr);
   endtask

   task automatic fwdTest();
      inst_t       seq[$];
      opcode_t     ops[8];
      logic [31:0] r;
      logic [1:0]  exp;
      int          startErr;
      startErr = errors;
      ops = '{OP_R, OP_I, OP_LOAD, OP_STORE, OP_BRANCH, OP_LUI, OP_JALR, OP_CSRW};
      seq.push_back(mkInst(OP_I, 5'd5, 3'd0, 5'd1, 5'd0, 1'b0));
      seq.push_back(mkInst(OP_R, 5'd6, 3'd0, 5'd5, 5'd2, 1'b0));
      seq.push_back(mkInst(OP_STORE, 5'd5, 3'd2, 5'd3, 5'd5, 1'b0));
      seq.push_back(mkInst(OP_R, 5'd0, 3'd0, 5'd6, 5'd6, 1'b0));
      seq.push_back(mkInst(OP_BRANCH, 5'd5, 3'd0, 5'd5, 5'd5, 1'b0));
      seq.push_back(mkInst(OP_R, 5'd0, 3'd0, 5'd0, 5'd0, 1'b0));
      // Reads x5 while the branch above sits in writeback
      seq.push_back(mkInst(OP_R, 5'd0, 3'd0, 5'd5, 5'd5, 1'b0));
      // CSRW reading x0 right behind an x0 writer
      seq.push_back(mkInst(OP_CSRW, 5'd0, 3'd1, 5'd0, 5'd0, 1'b0));
      seq.push_back(mkInst(OP_LOAD, 5'd8, 3'd2, 5'd0, 5'd0, 1'b0));
      seq.push_back(mkInst(OP_JALR, 5'd7, 3'd0, 5'd1, 5'd0, 1'b0));
      seq.push_back(mkInst(OP_I, 5'd9, 3'd0, 5'd8, 5'd7, 1'b0));
      seq.push_back(mkInst(OP_JAL, 5'd1, 3'd0, 5'd7, 5'd7, 1'b0));
      seq.push_back(mkInst(OP_R, 5'd2, 3'd0, 5'd9, 5'd7, 1'b0));
      // Small register range so random sources often collide
      for (int i = 0; i < FWD_RANDOM; i++) begin
         r = $random(seed);
         seq.push_back(mkInst(ops[r[2:0]], {3'b0, r[4:3]}, r[7:5], {3'b0, r[9:8]},
                              {3'b0, r[11:10]}, 1'b0));
      end
      seq.push_back(NOP);
      seq.push_back(NOP);
      for (int i = 0; i < seq.size(); i++) begin
         tick(seq[i], 1'b0, 1'b0, 32'h0);
         if (i >= 2) begin
            exp = expFwd(seq[i], seq[i - 2]);
            check("faDec", 32'(exp[1]), 32'(fwd.faDec));
            check("fbDec", 32'(exp[0]), 32'(fwd.fbDec));
            exp = expFwd(seq[i - 1], seq[i - 2]);
            check("faEx", 32'(exp[1]), 32'(fwd.faEx));
            check("fbEx", 32'(exp[0]), 32'(fwd.fbEx));
         end
      end
      report("forwarding", startErr);
   endtask

   initial begin
      rst    = 1'b1;
      inst   = NOP;
      brEq   = 1'b0;
      brLt   = 1'b0;
      aluOut = 32'h0;
      resetTest();
      selectTest();
      branchTest();
      memTest();
      wbTest();
      fwdTest();
      $display("checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog, all tests plus a margin of 20 cycles
   initial begin
      #((TOTAL_CYCLES + 20) * 100);
      $display("timeout: tests did not finish within %0d cycles", TOTAL_CYCLES + 20);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== flist.f ====
rtl/ctrlPkg.sv
rtl/instPipe.sv
rtl/decodeControl.sv
rtl/forwardUnit.sv
rtl/exControl.sv
rtl/wbControl.sv
rtl/pipeControl.sv
test/pipeControlTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pipeControl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
   -f flist.f --top-module pipeControlTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
exit 0
